//--- priv_block.f
hw/priv_csr_pkg.sv
hw/priv_pipe_pkg.sv
hw/priv_csr_rfile.sv
hw/priv_control.sv
hw/priv_pipeline_control.sv
hw/priv_block.sv
test/priv_block_checker.sv
test/priv_block_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the privilege unit testbench with Verilator, runs it and checks the result.
cd "$(dirname "$0")" &&
verilator --binary --timing --timescale 1ns/1ps -Wno-fatal \
  --top-module priv_block_tb -f priv_block.f &&
{
  sim_out="$(./obj_dir/Vpriv_block_tb)"
  echo "$sim_out"
  echo "$sim_out" | grep -qx "Test passed"
} ||
{ echo "Simulation did not pass"; exit 1; }

//--- test/priv_block_tb.sv
// Privilege unit testbench with clock, reset, directed and random stimulus and a reference model.
`timescale 1ns/1ps
`default_nettype none

module priv_block_tb;

  localparam logic [31:0] RESET_MTVEC  = 32'h0000_0400;
  localparam logic [31:0] HART_ID      = 32'h0000_0005;
  localparam logic [31:0] MISA_VALUE   = 32'h4000_0100;  // RV32I.
  localparam int          DIRECTED_LEN = 200;  // Upper bound including reset.
  localparam int          RANDOM_LEN   = 400;
  localparam int          CYCLE_LIMIT  = 2 * (DIRECTED_LEN + RANDOM_LEN) + 100;
  localparam logic [1:0]  MODE_SWAP = 2'd0, MODE_SET = 2'd1, MODE_CLR = 2'd2;
  // Exception codes and tval sources listed from highest priority down.
  localparam logic [8:0][3:0] PRIO_CODE = {4'd3, 4'd1, 4'd0, 4'd2, 4'd11, 4'd6, 4'd7, 4'd4, 4'd5};
  localparam logic [8:0]      PRIO_ADDR = 9'b0_1_1_0_0_1_1_1_1;

  // Shadow copy of the architectural CSR state.
  typedef struct packed {
    logic        mie;
    logic        mpie;
    logic        mtie;
    logic [31:0] mtvec;
    logic [31:0] mepc;
    logic [31:0] mcause;
    logic [31:0] mtval;
    logic [31:0] mscratch;
    logic [31:0] mcycle;
    logic [31:0] minstret;
  } shadow_t;

  logic                       CLK;
  logic                       arst_n;
  logic                       timer_int;
  logic                       check_en;
  priv_pipe_pkg::pipe_req_t   pipe_req;
  priv_pipe_pkg::csr_req_t    csr_req;
  priv_pipe_pkg::priv_resp_t  priv_resp;
  priv_pipe_pkg::priv_resp_t  exp_resp;  // Expected in the current cycle.
  priv_pipe_pkg::priv_resp_t  exp_next;  // Redirect fields after the next edge.
  shadow_t                    shadow;
  int                         errors, checks;
  int                         cycles = 0;

  priv_block #(.RESET_MTVEC(RESET_MTVEC), .HART_ID(HART_ID)) priv_block_inst (
    .CLK       (CLK),
    .arst_n    (arst_n),
    .pipe_req  (pipe_req),
    .csr_req   (csr_req),
    .timer_int (timer_int),
    .priv_resp (priv_resp)
  );

  priv_block_checker checker_inst (
    .CLK      (CLK),
    .check_en (check_en),
    .dut_resp (priv_resp),
    .exp_resp (exp_resp),
    .errors   (errors),
    .checks   (checks)
  );

  initial begin
    CLK = 1'b0;
    forever #5 CLK = ~CLK;
  end

  always @(posedge CLK) begin
    cycles = cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("Test failed");
      $finish;
    end
  end

  // Models one commit cycle. rdata and invalid_csr hold now and redirect fields after the edge.
  function automatic void priv_model(input shadow_t s, input priv_pipe_pkg::pipe_req_t p,
                                     input priv_pipe_pkg::csr_req_t c, input logic tmr,
                                     input logic [31:0] pc_now, output shadow_t n,
                                     output priv_pipe_pkg::priv_resp_t r);
    logic [31:0] cur, mask, wv;
    logic        known, pend, take_trap, take_ret, wr, tval_addr;
    logic [30:0] code;
    logic [8:0]  prio;
    int          i;
    n = s;
    r = '0;
    cur = '0;
    mask = '0;  // Writable bits.
    known = 1'b1;
    code = '0;
    tval_addr = 1'b0;
    case (c.addr)
      priv_csr_pkg::CSR_MSTATUS: begin
        cur  = {19'd0, 2'b11, 3'd0, s.mpie, 3'd0, s.mie, 3'd0};
        mask = 32'h0000_0088;
      end
      priv_csr_pkg::CSR_MISA:     cur = MISA_VALUE;
      priv_csr_pkg::CSR_MIE: begin
        cur  = {24'd0, s.mtie, 7'd0};
        mask = 32'h80;
      end
      priv_csr_pkg::CSR_MTVEC: begin
        cur  = s.mtvec;
        mask = 32'hFFFF_FFFD;
      end
      priv_csr_pkg::CSR_MSCRATCH: begin
        cur  = s.mscratch;
        mask = '1;
      end
      priv_csr_pkg::CSR_MEPC: begin
        cur  = s.mepc;
        mask = 32'hFFFF_FFFC;
      end
      priv_csr_pkg::CSR_MCAUSE: begin
        cur  = s.mcause;
        mask = '1;
      end
      priv_csr_pkg::CSR_MTVAL: begin
        cur  = s.mtval;
        mask = '1;
      end
      priv_csr_pkg::CSR_MIP:      cur = {24'd0, tmr, 7'd0};
      priv_csr_pkg::CSR_MCYCLE: begin
        cur  = s.mcycle;
        mask = '1;
      end
      priv_csr_pkg::CSR_MINSTRET: begin
        cur  = s.minstret;
        mask = '1;
      end
      priv_csr_pkg::CSR_MHARTID:  cur = HART_ID;
      default:                    known = 1'b0;
    endcase
    r.rdata       = cur;
    r.invalid_csr = !known || (c.valid_write && c.addr == priv_csr_pkg::CSR_MHARTID);
    wv = c.swap ? c.wdata : c.set ? (cur | c.wdata) : c.clr ? (cur & ~c.wdata) : cur;
    wv = (cur & ~mask) | (wv & mask);
    wr = c.valid_write && (c.swap || c.set || c.clr) && mask != '0;
    if (wr) begin
      case (c.addr)
        priv_csr_pkg::CSR_MSTATUS: begin
          n.mie  = wv[3];
          n.mpie = wv[7];
        end
        priv_csr_pkg::CSR_MIE:      n.mtie = wv[7];
        priv_csr_pkg::CSR_MTVEC:    n.mtvec = wv;
        priv_csr_pkg::CSR_MSCRATCH: n.mscratch = wv;
        priv_csr_pkg::CSR_MEPC:     n.mepc = wv;
        priv_csr_pkg::CSR_MCAUSE:   n.mcause = wv;
        priv_csr_pkg::CSR_MTVAL:    n.mtval = wv;
        priv_csr_pkg::CSR_MCYCLE:   n.mcycle = wv;
        priv_csr_pkg::CSR_MINSTRET: n.minstret = wv;
        default: ;
      endcase
    end
    if (!(wr && c.addr == priv_csr_pkg::CSR_MCYCLE)) n.mcycle = s.mcycle + 32'd1;
    if (!(wr && c.addr == priv_csr_pkg::CSR_MINSTRET) && p.wb_enable && p.instr)
      n.minstret = s.minstret + 32'd1;
    prio = {p.exc.breakpoint, p.exc.fault_insn, p.exc.mal_insn, p.exc.illegal_insn,
            p.exc.env_m, p.exc.mal_s, p.exc.fault_s, p.exc.mal_l, p.exc.fault_l};
    for (i = 0; i < 9; i++) begin
      if (prio[i]) begin  // Later hits rank higher.
        code      = {27'd0, PRIO_CODE[i]};
        tval_addr = PRIO_ADDR[i];
      end
    end
    pend      = s.mie && s.mtie && tmr;
    take_trap = p.pipe_clear && (pend || prio != '0);
    take_ret  = p.pipe_clear && p.ret && !take_trap;
    if (pend) code = 31'd7;  // Timer beats every exception.
    r.insert_pc = take_trap || take_ret;
    r.intr      = take_trap;
    r.priv_pc   = pc_now;
    if (take_trap) begin
      n.mepc    = p.epc;
      n.mcause  = {pend, code};
      n.mtval   = (tval_addr && !pend) ? p.badaddr : 32'd0;
      n.mpie    = s.mie;
      n.mie     = 1'b0;
      r.priv_pc = {s.mtvec[31:2], 2'b00};
      if (pend && s.mtvec[0]) r.priv_pc = r.priv_pc + {code[29:0], 2'b00};  // Vectored.
    end else if (take_ret) begin
      n.mie     = s.mpie;
      n.mpie    = 1'b1;
      r.priv_pc = s.mepc;
    end
  endfunction

  task automatic apply_inputs(input priv_pipe_pkg::pipe_req_t p,
                              input priv_pipe_pkg::csr_req_t c, input logic tmr);
    priv_pipe_pkg::priv_resp_t r;
    shadow_t                   n;
    pipe_req  = p;
    csr_req   = c;
    timer_int = tmr;
    exp_resp.priv_pc   = exp_next.priv_pc;  // Made by the edge just passed.
    exp_resp.insert_pc = exp_next.insert_pc;
    exp_resp.intr      = exp_next.intr;
    priv_model(shadow, p, c, tmr, exp_next.priv_pc, n, r);
    shadow               = n;
    exp_resp.rdata       = r.rdata;
    exp_resp.invalid_csr = r.invalid_csr;
    exp_next             = r;
  endtask

  task automatic drive_cycle(input priv_pipe_pkg::pipe_req_t p,
                             input priv_pipe_pkg::csr_req_t c, input logic tmr);
    @(posedge CLK);
    #1;
    apply_inputs(p, c, tmr);
  endtask

  task automatic read_csr(input priv_csr_pkg::csr_addr_t a);
    priv_pipe_pkg::csr_req_t c;
    c      = '0;
    c.addr = a;
    drive_cycle('0, c, 1'b0);
  endtask

  task automatic write_csr(input logic [1:0] mode, input priv_csr_pkg::csr_addr_t a,
                           input logic [31:0] d);
    priv_pipe_pkg::csr_req_t c;
    c             = '0;
    c.addr        = a;
    c.wdata       = d;
    c.valid_write = 1'b1;
    c.swap        = (mode == MODE_SWAP);
    c.set         = (mode == MODE_SET);
    c.clr         = (mode == MODE_CLR);
    drive_cycle('0, c, 1'b0);
    read_csr(a);  // Read back the masked value.
  endtask

  // Commit stage event followed by readback of the trap CSRs.
  task automatic commit_event(input logic [8:0] flags, input logic clear, input logic ret,
                              input logic tmr, input logic [31:0] epc);
    priv_pipe_pkg::pipe_req_t p;
    priv_pipe_pkg::csr_req_t  c;
    p            = '0;
    p.exc        = flags;
    p.pipe_clear = clear;
    p.ret        = ret;
    p.epc        = epc;
    p.badaddr    = epc + 32'h0000_0123;
    c            = '0;
    c.addr       = priv_csr_pkg::CSR_MCAUSE;
    drive_cycle(p, c, tmr);
    read_csr(priv_csr_pkg::CSR_MEPC);
    read_csr(priv_csr_pkg::CSR_MCAUSE);
    read_csr(priv_csr_pkg::CSR_MTVAL);
  endtask

  function automatic priv_csr_pkg::csr_addr_t pick_addr(input logic [3:0] k);
    case (k)
      4'd0:    return priv_csr_pkg::CSR_MSTATUS;
      4'd1:    return priv_csr_pkg::CSR_MISA;
      4'd2:    return priv_csr_pkg::CSR_MIE;
      4'd3:    return priv_csr_pkg::CSR_MTVEC;
      4'd4:    return priv_csr_pkg::CSR_MSCRATCH;
      4'd5:    return priv_csr_pkg::CSR_MEPC;
      4'd6:    return priv_csr_pkg::CSR_MCAUSE;
      4'd7:    return priv_csr_pkg::CSR_MTVAL;
      4'd8:    return priv_csr_pkg::CSR_MIP;
      4'd9:    return priv_csr_pkg::CSR_MCYCLE;
      4'd10:   return priv_csr_pkg::CSR_MINSTRET;
      4'd11:   return priv_csr_pkg::CSR_MHARTID;
      default: return priv_csr_pkg::csr_addr_t'(12'hF00 | {8'd0, k});  // Unknown address.
    endcase
  endfunction

  initial begin
    priv_pipe_pkg::pipe_req_t p;
    priv_pipe_pkg::csr_req_t  c;
    logic [31:0]              rnd;
    logic [8:0]               flags;
    logic                     tmr;
    int                       i;
    int                       first_bit, second_bit;
    void'($urandom(42));
    arst_n       = 1'b0;
    pipe_req     = '0;
    csr_req      = '0;
    timer_int    = 1'b0;
    check_en     = 1'b0;
    exp_resp     = '0;
    exp_next     = '0;
    shadow       = '0;
    shadow.mtvec = RESET_MTVEC;
    repeat (8) @(posedge CLK);
    #1 arst_n = 1'b1;
    c      = '0;
    c.addr = priv_csr_pkg::CSR_MHARTID;
    apply_inputs('0, c, 1'b0);
    check_en = 1'b1;

    // CSR access modes and masks.
    read_csr(priv_csr_pkg::CSR_MISA);
    read_csr(priv_csr_pkg::CSR_MTVEC);
    write_csr(MODE_SWAP, priv_csr_pkg::CSR_MSCRATCH, 32'hDEAD_BEEF);
    write_csr(MODE_SET, priv_csr_pkg::CSR_MSCRATCH, 32'h0000_00F0);
    write_csr(MODE_CLR, priv_csr_pkg::CSR_MSCRATCH, 32'hDE00_000F);
    write_csr(MODE_SWAP, priv_csr_pkg::CSR_MTVEC, 32'h0000_1003);  // Mode bit 1 stays zero.
    write_csr(MODE_SWAP, priv_csr_pkg::CSR_MTVEC, 32'h0000_2000);
    write_csr(MODE_SET, priv_csr_pkg::CSR_MTVEC, 32'h0000_0003);
    write_csr(MODE_CLR, priv_csr_pkg::CSR_MTVEC, 32'h0000_0001);
    write_csr(MODE_SET, priv_csr_pkg::CSR_MIE, 32'hFFFF_FFFF);
    write_csr(MODE_CLR, priv_csr_pkg::CSR_MIE, 32'h0000_0080);
    read_csr(priv_csr_pkg::csr_addr_t'(12'h7C0));
    write_csr(MODE_SWAP, priv_csr_pkg::CSR_MHARTID, 32'h1234_5678);

    // Single exceptions and then all flags without pipe_clear.
    for (i = 0; i < 9; i++) commit_event(9'd1 << i, 1'b1, 1'b0, 1'b0, 32'h0000_8000 + i * 4);
    commit_event(9'h1FF, 1'b0, 1'b0, 1'b0, 32'h0000_9000);

    // Several flags at once pick mcause by priority.
    for (i = 0; i < 18; i++) begin
      rnd        = $urandom;
      first_bit  = rnd[7:0] % 9;
      second_bit = (first_bit + 1 + rnd[15:8] % 8) % 9;
      flags      = (9'd1 << first_bit) | (9'd1 << second_bit) | (rnd[24:16] & rnd[31:23]);
      commit_event(flags, 1'b1, 1'b0, 1'b0, 32'h0000_D000 + i * 4);
    end

    // Timer interrupt over a breakpoint in direct mode.
    write_csr(MODE_SET, priv_csr_pkg::CSR_MSTATUS, 32'h0000_0008);
    write_csr(MODE_SWAP, priv_csr_pkg::CSR_MIE, 32'h0000_0080);
    commit_event(9'h002, 1'b1, 1'b0, 1'b1, 32'h0000_A000);
    read_csr(priv_csr_pkg::CSR_MSTATUS);
    // Vectored mode jumps to base + 28.
    write_csr(MODE_SWAP, priv_csr_pkg::CSR_MTVEC, 32'h0000_3001);
    write_csr(MODE_SET, priv_csr_pkg::CSR_MSTATUS, 32'h0000_0008);
    commit_event(9'h040, 1'b1, 1'b0, 1'b1, 32'h0000_B000);
    // mret to the saved mepc.
    commit_event(9'h000, 1'b1, 1'b1, 1'b0, 32'h0000_C000);
    read_csr(priv_csr_pkg::CSR_MSTATUS);

    // Retirement counter against random writeback pulses.
    read_csr(priv_csr_pkg::CSR_MCYCLE);
    for (i = 0; i < 12; i++) begin
      rnd         = $urandom;
      p           = '0;
      p.wb_enable = rnd[0];
      p.instr     = rnd[1];
      c           = '0;
      c.addr      = priv_csr_pkg::CSR_MINSTRET;
      drive_cycle(p, c, 1'b0);
    end
    read_csr(priv_csr_pkg::CSR_MCYCLE);

    // Random mix of commits, CSR traffic and timer.
    for (i = 0; i < RANDOM_LEN; i++) begin
      rnd          = $urandom;
      p            = '0;
      c            = '0;
      p.pipe_clear = (rnd[1:0] == 2'b00);
      p.ret        = rnd[2];
      p.exc        = (rnd[4:3] == 2'b00) ? rnd[31:23] : 9'd0;
      p.wb_enable  = rnd[5];
      p.instr      = rnd[6];
      c.addr       = pick_addr(rnd[10:7]);
      if (rnd[13:11] == 3'b000) begin
        c.valid_write = 1'b1;
        c.swap        = (rnd[15:14] == 2'd0);
        c.set         = (rnd[15:14] == 2'd1);
        c.clr         = rnd[15];
      end
      tmr       = rnd[16];
      rnd       = $urandom;
      p.epc     = {rnd[31:2], 2'b00};
      p.badaddr = ~rnd;
      c.wdata   = $urandom;
      drive_cycle(p, c, tmr);
    end
    read_csr(priv_csr_pkg::CSR_MSTATUS);

    @(negedge CLK);
    #1;
    $display("Run finished: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- test/priv_block_checker.sv
// Response checker for the privilege unit, compares DUT outputs with the model each cycle.
`timescale 1ns/1ps
`default_nettype none

module priv_block_checker (
  input  logic                       CLK,
  input  logic                       check_en,  // Low during reset.
  input  priv_pipe_pkg::priv_resp_t  dut_resp,
  input  priv_pipe_pkg::priv_resp_t  exp_resp,
  output int                         errors,
  output int                         checks
);

  int err_count   = 0;
  int check_count = 0;

  assign errors = err_count;
  assign checks = check_count;

  task automatic compare_field(input string name, input logic [31:0] exp_val,
                               input logic [31:0] got_val);
    check_count++;
    if (got_val !== exp_val) begin
      err_count++;
      $display("CHECK FAILED: %s expected 0x%h got 0x%h at %0t",
               name, exp_val, got_val, $time);
    end
  endtask

  // Mid-cycle sample. Inputs and registered outputs have both settled.
  always @(negedge CLK) begin
    if (check_en) begin
      compare_field("priv_resp.rdata", exp_resp.rdata, dut_resp.rdata);
      compare_field("priv_resp.invalid_csr", {31'd0, exp_resp.invalid_csr},
                    {31'd0, dut_resp.invalid_csr});
      compare_field("priv_resp.insert_pc", {31'd0, exp_resp.insert_pc},
                    {31'd0, dut_resp.insert_pc});
      compare_field("priv_resp.intr", {31'd0, exp_resp.intr}, {31'd0, dut_resp.intr});
      compare_field("priv_resp.priv_pc", exp_resp.priv_pc, dut_resp.priv_pc);  // Held value too.
    end
  end

endmodule

`default_nettype wire

//--- hw/priv_block.sv
// Machine-mode privilege unit top level: CSR file, trap controller and redirect logic.
`timescale 1ns/1ps
`default_nettype none

module priv_block #(
  parameter logic [31:0] RESET_MTVEC = 32'h0000_0100,
  parameter logic [31:0] HART_ID     = 32'd0
) (
  input  logic                       CLK,
  input  logic                       arst_n,
  input  priv_pipe_pkg::pipe_req_t   pipe_req,
  input  priv_pipe_pkg::csr_req_t    csr_req,
  input  logic                       timer_int,
  output priv_pipe_pkg::priv_resp_t  priv_resp
);

  priv_pipe_pkg::trap_req_t trap;     // Trap or return decision.
  priv_csr_pkg::mstatus_t   mstatus;
  priv_csr_pkg::mie_t       mie;
  priv_csr_pkg::mip_t       mip;
  priv_csr_pkg::mtvec_t     mtvec;
  logic [31:0]              mepc;

  priv_csr_rfile #(
    .RESET_MTVEC (RESET_MTVEC),
    .HART_ID     (HART_ID)
  ) csr_rfile_inst (
    .CLK         (CLK),
    .arst_n      (arst_n),
    .csr_req     (csr_req),
    .pipe_req    (pipe_req),
    .trap        (trap),
    .timer_int   (timer_int),
    .rdata       (priv_resp.rdata),
    .invalid_csr (priv_resp.invalid_csr),
    .mstatus     (mstatus),
    .mie         (mie),
    .mip         (mip),
    .mtvec       (mtvec),
    .mepc        (mepc)
  );

  priv_control control_inst (
    .pipe_req (pipe_req),
    .mstatus  (mstatus),
    .mie      (mie),
    .mip      (mip),
    .trap     (trap)
  );

  priv_pipeline_control pipeline_control_inst (
    .CLK       (CLK),
    .arst_n    (arst_n),
    .trap      (trap),
    .mtvec     (mtvec),
    .mepc      (mepc),
    .priv_pc   (priv_resp.priv_pc),
    .insert_pc (priv_resp.insert_pc),
    .intr      (priv_resp.intr)
  );

endmodule

`default_nettype wire

//--- hw/priv_pipeline_control.sv
// Redirect controller: picks the trap or mret target and strobes it to the pipeline.
`timescale 1ns/1ps
`default_nettype none

module priv_pipeline_control (
  input  logic                      CLK,
  input  logic                      arst_n,
  input  priv_pipe_pkg::trap_req_t  trap,
  input  priv_csr_pkg::mtvec_t      mtvec,
  input  logic [31:0]               mepc,
  output logic [31:0]               priv_pc,
  output logic                      insert_pc,
  output logic                      intr
);

  logic [29:0] vec_base;  // Word address of the vectored entry.
  logic [31:0] target;

  assign vec_base = mtvec.base + trap.cause_code[29:0];

  always_comb begin
    if (trap.take_ret) begin
      target = mepc;  // Value before this edge.
    end else if (trap.is_intr && mtvec.mode == priv_csr_pkg::MTVEC_VECTORED) begin
      target = {vec_base, 2'b00};
    end else begin
      target = {mtvec.base, 2'b00};  // Exceptions always go to base.
    end
  end

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      priv_pc   <= '0;
      insert_pc <= 1'b0;
      intr      <= 1'b0;
    end else begin
      insert_pc <= trap.take_trap || trap.take_ret;  // One-cycle strobe.
      intr      <= trap.take_trap;
      if (trap.take_trap || trap.take_ret) priv_pc <= target;
    end
  end

  // mtvec and mepc keep their low bits clear.
  a_target_aligned: assert property (@(posedge CLK) disable iff (!arst_n)
    insert_pc |-> (priv_pc[1:0] == 2'b00));

endmodule

`default_nettype wire

//--- hw/priv_control.sv
// Trap controller that resolves interrupt and exception priority, encodes the cause and gates returns.
`timescale 1ns/1ps
`default_nettype none

module priv_control (
  input  priv_pipe_pkg::pipe_req_t  pipe_req,
  input  priv_csr_pkg::mstatus_t    mstatus,
  input  priv_csr_pkg::mie_t        mie,
  input  priv_csr_pkg::mip_t        mip,
  output priv_pipe_pkg::trap_req_t  trap
);

  localparam logic [30:0] INT_CODE_MSI = 31'd3;   // Machine software interrupt.
  localparam logic [30:0] INT_CODE_MEI = 31'd11;  // Machine external interrupt.

  logic soft_pend;  // No software interrupt source.
  logic ext_pend;   // No interrupt controller.
  logic timer_pend;
  logic int_pend;
  logic exc_any;
  priv_pipe_pkg::exc_flags_t exc;

  assign soft_pend  = 1'b0;
  assign ext_pend   = 1'b0;
  assign timer_pend = mstatus.mie && mie.mtie && mip.mtip;
  assign int_pend   = mstatus.mie && (ext_pend || soft_pend) || timer_pend;
  assign exc        = pipe_req.exc;
  assign exc_any    = |exc;

  always_comb begin
    trap            = '0;
    trap.take_trap  = pipe_req.pipe_clear && (int_pend || exc_any);
    trap.take_ret   = pipe_req.pipe_clear && pipe_req.ret && !trap.take_trap;
    trap.is_intr    = int_pend;  // Interrupts beat every exception.

    if (int_pend) begin
      if (ext_pend) trap.cause_code = INT_CODE_MEI;
      else if (soft_pend) trap.cause_code = INT_CODE_MSI;
      else trap.cause_code = priv_csr_pkg::INT_CODE_MTI;
    end else if (exc.breakpoint) begin
      trap.cause_code = priv_csr_pkg::EXC_BREAKPOINT;
    end else if (exc.fault_insn) begin
      trap.cause_code = priv_csr_pkg::EXC_INSN_FAULT;
      trap.tval_sel   = 1'b1;
    end else if (exc.mal_insn) begin
      trap.cause_code = priv_csr_pkg::EXC_INSN_MISALIGNED;
      trap.tval_sel   = 1'b1;
    end else if (exc.illegal_insn) begin
      trap.cause_code = priv_csr_pkg::EXC_ILLEGAL_INSN;
    end else if (exc.env_m) begin
      trap.cause_code = priv_csr_pkg::EXC_ENV_CALL_M;
    end else if (exc.mal_s) begin
      trap.cause_code = priv_csr_pkg::EXC_STORE_MISALIGNED;
      trap.tval_sel   = 1'b1;
    end else if (exc.fault_s) begin
      trap.cause_code = priv_csr_pkg::EXC_STORE_FAULT;
      trap.tval_sel   = 1'b1;
    end else if (exc.mal_l) begin
      trap.cause_code = priv_csr_pkg::EXC_LOAD_MISALIGNED;
      trap.tval_sel   = 1'b1;
    end else if (exc.fault_l) begin
      trap.cause_code = priv_csr_pkg::EXC_LOAD_FAULT;
      trap.tval_sel   = 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- hw/priv_csr_rfile.sv
// Machine-mode CSR register file with access decode, trap side effects and counters.
`timescale 1ns/1ps
`default_nettype none

module priv_csr_rfile #(
  parameter logic [31:0] RESET_MTVEC = 32'h0000_0100,
  parameter logic [31:0] HART_ID     = 32'd0
) (
  input  logic                      CLK,
  input  logic                      arst_n,
  input  priv_pipe_pkg::csr_req_t   csr_req,
  input  priv_pipe_pkg::pipe_req_t  pipe_req,
  input  priv_pipe_pkg::trap_req_t  trap,
  input  logic                      timer_int,
  output logic [31:0]               rdata,
  output logic                      invalid_csr,
  output priv_csr_pkg::mstatus_t    mstatus,
  output priv_csr_pkg::mie_t        mie,
  output priv_csr_pkg::mip_t        mip,
  output priv_csr_pkg::mtvec_t      mtvec,
  output logic [31:0]               mepc
);

  localparam logic [31:0] MISA_VALUE = 32'h4000_0100;  // RV32I.

  logic                   mie_bit, mpie_bit;  // Live mstatus bits.
  logic                   mtie_bit;
  priv_csr_pkg::mtvec_t   mtvec_r;
  logic [31:0]            mepc_r;
  priv_csr_pkg::mcause_t  mcause_r;
  logic [31:0]            mtval_r;
  logic [31:0]            mscratch_r;
  logic [31:0]            mcycle_r;
  logic [31:0]            minstret_r;

  logic                   addr_known;
  logic                   read_only;
  logic                   wr_en;
  logic [31:0]            wval;        // Value after swap/set/clear.
  priv_csr_pkg::mstatus_t wval_status; // Field views of wval.
  priv_csr_pkg::mie_t     wval_mie;
  priv_csr_pkg::mtvec_t   wval_mtvec;
  logic                   retire;

  // Status words out to the trap and redirect logic.
  always_comb begin
    mstatus      = '0;
    mstatus.mpp  = 2'b11;  // Machine mode only.
    mstatus.mpie = mpie_bit;
    mstatus.mie  = mie_bit;
    mie          = '0;
    mie.mtie     = mtie_bit;
    mip          = '0;
    mip.mtip     = timer_int;  // Mirrors the timer line.
  end

  assign mtvec = mtvec_r;
  assign mepc  = mepc_r;

  // Read mux.
  always_comb begin
    rdata      = '0;
    addr_known = 1'b1;
    case (csr_req.addr)
      priv_csr_pkg::CSR_MSTATUS:  rdata = mstatus;
      priv_csr_pkg::CSR_MISA:     rdata = MISA_VALUE;
      priv_csr_pkg::CSR_MIE:      rdata = mie;
      priv_csr_pkg::CSR_MTVEC:    rdata = mtvec_r;
      priv_csr_pkg::CSR_MSCRATCH: rdata = mscratch_r;
      priv_csr_pkg::CSR_MEPC:     rdata = mepc_r;
      priv_csr_pkg::CSR_MCAUSE:   rdata = mcause_r;
      priv_csr_pkg::CSR_MTVAL:    rdata = mtval_r;
      priv_csr_pkg::CSR_MIP:      rdata = mip;
      priv_csr_pkg::CSR_MCYCLE:   rdata = mcycle_r;
      priv_csr_pkg::CSR_MINSTRET: rdata = minstret_r;
      priv_csr_pkg::CSR_MHARTID:  rdata = HART_ID;
      default:                    addr_known = 1'b0;
    endcase
  end

  assign read_only   = (csr_req.addr[11:10] == 2'b11);
  assign invalid_csr = !addr_known || (csr_req.valid_write && read_only);

  // Write modes, first hit wins.
  always_comb begin
    if (csr_req.swap) wval = csr_req.wdata;
    else if (csr_req.set) wval = rdata | csr_req.wdata;
    else if (csr_req.clr) wval = rdata & ~csr_req.wdata;
    else wval = rdata;
  end

  assign wr_en = csr_req.valid_write && addr_known && !read_only &&
                 (csr_req.swap || csr_req.set || csr_req.clr);

  assign wval_status = wval;
  assign wval_mie    = wval;
  assign wval_mtvec  = wval;
  assign retire      = pipe_req.wb_enable && pipe_req.instr;

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      mie_bit    <= 1'b0;
      mpie_bit   <= 1'b0;
      mtie_bit   <= 1'b0;
      mtvec_r    <= RESET_MTVEC;
      mepc_r     <= '0;
      mcause_r   <= '0;
      mtval_r    <= '0;
      mscratch_r <= '0;
      mcycle_r   <= '0;
      minstret_r <= '0;
    end else begin
      // Trap and return beat a CSR write to the same register.
      if (trap.take_trap) begin
        mpie_bit <= mie_bit;
        mie_bit  <= 1'b0;
      end else if (trap.take_ret) begin
        mie_bit  <= mpie_bit;
        mpie_bit <= 1'b1;
      end else if (wr_en && csr_req.addr == priv_csr_pkg::CSR_MSTATUS) begin
        mie_bit  <= wval_status.mie;
        mpie_bit <= wval_status.mpie;
      end

      if (trap.take_trap) begin
        mepc_r             <= {pipe_req.epc[31:2], 2'b00};  // IALIGN 32.
        mcause_r.interrupt <= trap.is_intr;
        mcause_r.code      <= trap.cause_code;
        mtval_r            <= trap.tval_sel ? pipe_req.badaddr : 32'd0;
      end else if (wr_en) begin
        if (csr_req.addr == priv_csr_pkg::CSR_MEPC) mepc_r <= {wval[31:2], 2'b00};
        if (csr_req.addr == priv_csr_pkg::CSR_MCAUSE) mcause_r <= wval;
        if (csr_req.addr == priv_csr_pkg::CSR_MTVAL) mtval_r <= wval;
      end

      if (wr_en && csr_req.addr == priv_csr_pkg::CSR_MIE) mtie_bit <= wval_mie.mtie;
      if (wr_en && csr_req.addr == priv_csr_pkg::CSR_MSCRATCH) mscratch_r <= wval;
      if (wr_en && csr_req.addr == priv_csr_pkg::CSR_MTVEC) begin
        mtvec_r.base <= wval_mtvec.base;
        mtvec_r.mode <= priv_csr_pkg::mtvec_mode_e'({1'b0, wval_mtvec.mode[0]});  // WARL.
      end

      // Counters. A CSR write replaces the increment.
      if (wr_en && csr_req.addr == priv_csr_pkg::CSR_MCYCLE) mcycle_r <= wval;
      else mcycle_r <= mcycle_r + 32'd1;

      if (wr_en && csr_req.addr == priv_csr_pkg::CSR_MINSTRET) minstret_r <= wval;
      else if (retire) minstret_r <= minstret_r + 32'd1;
    end
  end

  // One CSR instruction type per access.
  a_one_write_mode: assert property (@(posedge CLK) disable iff (!arst_n)
    $onehot0({csr_req.swap, csr_req.set, csr_req.clr}));

endmodule

`default_nettype wire

//--- hw/priv_pipe_pkg.sv
// Pipeline-side package: request and response bundles of the privilege unit.
`default_nettype none

package priv_pipe_pkg;

  // Exception flags raised by the commit stage.
  typedef struct packed {
    logic fault_insn;    // Instruction access fault.
    logic mal_insn;      // Misaligned fetch.
    logic illegal_insn;
    logic fault_l;       // Load access fault.
    logic mal_l;
    logic fault_s;       // Store access fault.
    logic mal_s;
    logic breakpoint;    // ebreak.
    logic env_m;         // ecall from machine mode.
  } exc_flags_t;

  // Commit-stage status for the current instruction.
  typedef struct packed {
    logic        pipe_clear;  // Pipeline drained, a redirect is safe.
    logic        ret;         // mret at commit.
    exc_flags_t  exc;
    logic [31:0] epc;         // PC of the committing instruction.
    logic [31:0] badaddr;     // Faulting address.
    logic        wb_enable;
    logic        instr;       // Valid instruction in writeback.
  } pipe_req_t;

  // CSR instruction access.
  typedef struct packed {
    logic                   swap;         // csrrw.
    logic                   set;          // csrrs.
    logic                   clr;          // csrrc.
    logic                   valid_write;
    priv_csr_pkg::csr_addr_t addr;
    logic [31:0]            wdata;
  } csr_req_t;

  // Answer back to the pipeline.
  typedef struct packed {
    logic [31:0] priv_pc;      // Redirect target.
    logic        insert_pc;    // One-cycle redirect strobe.
    logic        intr;         // Redirect came from a trap.
    logic [31:0] rdata;
    logic        invalid_csr;
  } priv_resp_t;

  // Decision from the trap controller to the CSRs and the redirect logic.
  typedef struct packed {
    logic        take_trap;
    logic        take_ret;
    logic        is_intr;
    logic [30:0] cause_code;
    logic        tval_sel;    // High loads badaddr into mtval, low loads zero.
  } trap_req_t;

endpackage

`default_nettype wire

//--- hw/priv_csr_pkg.sv
// Machine-mode CSR package: CSR addresses, CSR field layouts and trap cause codes.
`default_nettype none

package priv_csr_pkg;

  // Machine-mode CSR addresses, low counter words only.
  typedef enum logic [11:0] {
    CSR_MSTATUS  = 12'h300,
    CSR_MISA     = 12'h301,
    CSR_MIE      = 12'h304,
    CSR_MTVEC    = 12'h305,
    CSR_MSCRATCH = 12'h340,
    CSR_MEPC     = 12'h341,
    CSR_MCAUSE   = 12'h342,
    CSR_MTVAL    = 12'h343,
    CSR_MIP      = 12'h344,
    CSR_MCYCLE   = 12'hB00,
    CSR_MINSTRET = 12'hB02,
    CSR_MHARTID  = 12'hF14  // Read-only space, addr[11:10] == 2'b11.
  } csr_addr_t;

  // mstatus, only the machine-mode fields are live.
  typedef struct packed {
    logic [31:13] reserved_hi;
    logic [1:0]   mpp;         // Previous privilege. Always machine.
    logic [10:8]  reserved_mid;
    logic         mpie;        // Saved MIE.
    logic [6:4]   reserved_lo;
    logic         mie;         // Global machine interrupt enable.
    logic [2:0]   reserved_bot;
  } mstatus_t;

  typedef enum logic [1:0] {
    MTVEC_DIRECT   = 2'b00,  // All traps go to base.
    MTVEC_VECTORED = 2'b01   // Interrupts go to base + 4 * code.
  } mtvec_mode_e;

  typedef struct packed {
    logic [29:0] base;  // Word address of the handler.
    mtvec_mode_e mode;
  } mtvec_t;

  typedef struct packed {
    logic        interrupt;
    logic [30:0] code;
  } mcause_t;

  // Only the timer bit exists. Software and external bits stay zero.
  typedef struct packed {
    logic [31:8] reserved_hi;
    logic        mtie;
    logic [6:0]  reserved_lo;
  } mie_t;

  typedef struct packed {
    logic [31:8] reserved_hi;
    logic        mtip;
    logic [6:0]  reserved_lo;
  } mip_t;

  // Synchronous exception codes for mcause.
  typedef enum logic [30:0] {
    EXC_INSN_MISALIGNED  = 31'd0,
    EXC_INSN_FAULT       = 31'd1,
    EXC_ILLEGAL_INSN     = 31'd2,
    EXC_BREAKPOINT       = 31'd3,
    EXC_LOAD_MISALIGNED  = 31'd4,
    EXC_LOAD_FAULT       = 31'd5,
    EXC_STORE_MISALIGNED = 31'd6,
    EXC_STORE_FAULT      = 31'd7,
    EXC_ENV_CALL_M       = 31'd11
  } exc_code_e;

  localparam logic [30:0] INT_CODE_MTI = 31'd7;  // Machine timer interrupt.

endpackage

`default_nettype wire
